// ==== all.f ====
common/sched_pkg.sv
design/prog_store.sv
scheduler/frame_sequencer.sv
scheduler/msg_issue.sv
cores/core_cluster.sv
design/gpu_top.sv
testbench/gpu_sva.sv
testbench/gpu_tb.sv

// ==== common/sched_pkg.sv ====
package sched_pkg;

    // geometry
    localparam int word_w       = 16;     // bus and memory word
    localparam int data_depth   = 1024;   // program words
    localparam int addr_w       = 10;     // store address
    localparam int frame_size   = 16;     // words per frame
    localparam int word_ptr_w   = 4;      // word index inside a frame
    localparam int core_num     = 16;
    localparam int r0_first     = 8;      // first r0 word of a header frame
    localparam int r0_depth     = 8;
    localparam int queue_depth  = 4;      // per core instruction queue
    localparam int queue_ptr_w  = 2;
    localparam int instr_busy_w = 4;      // busy cycles minus one, low bits of instr

    // fence kinds, bits [7:6] of the header
    localparam logic [1:0] fence_none = 2'd0;
    localparam logic [1:0] fence_acq  = 2'd1;
    localparam logic [1:0] fence_rel  = 2'd2;

    // sequencer fsm codes
    localparam logic [2:0] st_idle     = 3'd0;   // after reset, waits for a load
    localparam logic [2:0] st_hdr_rd   = 3'd1;   // header word read
    localparam logic [2:0] st_hdr_wait = 3'd2;   // header data returns
    localparam logic [2:0] st_hdr_dec  = 3'd3;   // decode + release fence
    localparam logic [2:0] st_body     = 3'd4;   // header words and instr frames
    localparam logic [2:0] st_done     = 3'd5;   // zero header seen

    // what the message bus carries
    typedef enum logic [2:0] {
        msg_none,
        msg_core_mask,
        msg_r0_mask,
        msg_r0_data,
        msg_instr
    } msg_kind_t;

    // program word, raw or header view
    typedef union packed {
        logic [word_w-1:0] raw;
        struct packed {
            logic [7:0] reserved;
            logic [1:0] fence;
            logic [5:0] if_num;   // instr frames following the header
        } header;
    } sched_word_u;

endpackage

// ==== cores/core_cluster.sv ====
module core_cluster (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [sched_pkg::word_w-1:0]   mess_to_core,
    input  logic                           core_mask_loading,
    input  logic                           r0_mask_loading,
    input  logic                           r0_loading,
    input  logic                           instr_loading,
    output logic [sched_pkg::core_num-1:0] core_ready,
    output logic [sched_pkg::core_num-1:0] core_reading
);

    logic [sched_pkg::core_num-1:0]         core_mask;   // cores of the current task
    logic [sched_pkg::core_num-1:0]         r0_mask;     // cores taking r0 data
    logic [$clog2(sched_pkg::r0_depth)-1:0] r0_slot;     // next r0 slot, shared by all cores

    // masks and r0 slot order, common to every core
    always_ff @(posedge clk) begin
        if (reset) begin
            core_mask <= '0;
            r0_mask   <= '0;
            r0_slot   <= '0;
        end else begin
            if (core_mask_loading) begin
                core_mask <= mess_to_core;
            end
            if (r0_mask_loading) begin
                r0_mask <= mess_to_core;
                r0_slot <= '0;   // r0 words follow the mask
            end else if (r0_loading) begin
                r0_slot <= r0_slot + 1'b1;
            end
        end
    end

    genvar g;
    generate
        for (g = 0; g < sched_pkg::core_num; g++) begin : g_core
            logic [sched_pkg::word_w-1:0]       r0_file [sched_pkg::r0_depth];
            logic [sched_pkg::word_w-1:0]       q_mem [sched_pkg::queue_depth];
            logic [sched_pkg::queue_ptr_w-1:0]  wr_ptr;
            logic [sched_pkg::queue_ptr_w-1:0]  rd_ptr;
            logic [sched_pkg::queue_ptr_w:0]    q_cnt;      // 0..4 entries
            logic [sched_pkg::instr_busy_w-1:0] busy_cnt;   // cycles left minus one
            logic                               busy;
            logic                               push;
            logic                               pop;

            assign push = instr_loading & core_mask[g];
            assign pop  = !busy && (q_cnt != '0);   // take the next instr when idle

            always_ff @(posedge clk) begin
                if (reset) begin
                    wr_ptr   <= '0;
                    rd_ptr   <= '0;
                    q_cnt    <= '0;
                    busy     <= 1'b0;
                    busy_cnt <= '0;
                end else begin
                    if (push) begin
                        wr_ptr <= wr_ptr + 1'b1;
                    end
                    if (pop) begin
                        rd_ptr <= rd_ptr + 1'b1;
                    end
                    q_cnt <= q_cnt + {{sched_pkg::queue_ptr_w{1'b0}}, push}
                                   - {{sched_pkg::queue_ptr_w{1'b0}}, pop};
                    if (pop) begin
                        busy     <= 1'b1;
                        busy_cnt <= q_mem[rd_ptr][sched_pkg::instr_busy_w-1:0];
                    end else if (busy) begin
                        if (busy_cnt == '0) begin
                            busy <= 1'b0;   // low bits + 1 cycles spent
                        end else begin
                            busy_cnt <= busy_cnt - 1'b1;
                        end
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (push) begin
                    q_mem[wr_ptr] <= mess_to_core;
                end
                if (r0_loading && r0_mask[g]) begin
                    r0_file[r0_slot] <= mess_to_core;
                end
            end

            assign core_ready[g] = !busy && (q_cnt == '0);

            // two free slots left after this cycle's push, for the words in flight
            assign core_reading[g] = (q_cnt + {{sched_pkg::queue_ptr_w{1'b0}}, push})
                                     <= (sched_pkg::queue_depth - 2);
        end
    endgenerate

endmodule

// ==== design/gpu_top.sv ====
module gpu_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           prog_loading,
    input  logic                           prog_we,
    input  logic [sched_pkg::addr_w-1:0]   prog_addr,
    input  logic [sched_pkg::word_w-1:0]   prog_data,
    output logic [sched_pkg::word_w-1:0]   mess_to_core,
    output logic                           core_mask_loading,
    output logic                           r0_mask_loading,
    output logic                           r0_loading,
    output logic                           instr_loading,
    output logic [sched_pkg::core_num-1:0] core_ready,
    output logic                           done
);

    logic                           rd_en;
    logic [sched_pkg::addr_w-1:0]   rd_addr;
    logic [sched_pkg::word_w-1:0]   rd_data;
    sched_pkg::msg_kind_t           rd_kind;
    logic [sched_pkg::core_num-1:0] core_reading;   // back-pressure from the cores

    prog_store u_store (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    frame_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .prog_loading (prog_loading),
        .rd_data      (rd_data),
        .core_reading (core_reading),
        .core_ready   (core_ready),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_kind      (rd_kind),
        .done         (done)
    );

    msg_issue u_issue (
        .clk               (clk),
        .reset             (reset),
        .rd_kind           (rd_kind),
        .rd_data           (rd_data),
        .mess_to_core      (mess_to_core),
        .core_mask_loading (core_mask_loading),
        .r0_mask_loading   (r0_mask_loading),
        .r0_loading        (r0_loading),
        .instr_loading     (instr_loading)
    );

    core_cluster u_cores (
        .clk               (clk),
        .reset             (reset),
        .mess_to_core      (mess_to_core),
        .core_mask_loading (core_mask_loading),
        .r0_mask_loading   (r0_mask_loading),
        .r0_loading        (r0_loading),
        .instr_loading     (instr_loading),
        .core_ready        (core_ready),
        .core_reading      (core_reading)
    );

endmodule

// ==== design/prog_store.sv ====
module prog_store (
    input  logic                         clk,
    input  logic                         prog_we,
    input  logic [sched_pkg::addr_w-1:0] prog_addr,
    input  logic [sched_pkg::word_w-1:0] prog_data,
    input  logic                         rd_en,
    input  logic [sched_pkg::addr_w-1:0] rd_addr,
    output logic [sched_pkg::word_w-1:0] rd_data
);

    // whole program image, one word per entry
    sched_pkg::sched_word_u mem [sched_pkg::data_depth];

    sched_pkg::sched_word_u rd_q;   // read register, holds between reads

    // write side, only driven while loading
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr].raw <= prog_data;
        end
    end

    // read side, data shows up one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    assign rd_data = rd_q.raw;

endmodule

// ==== scheduler/frame_sequencer.sv ====
module frame_sequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             prog_loading,
    input  logic [sched_pkg::word_w-1:0]     rd_data,
    input  logic [sched_pkg::core_num-1:0]   core_reading,
    input  logic [sched_pkg::core_num-1:0]   core_ready,
    output logic                             rd_en,
    output logic [sched_pkg::addr_w-1:0]     rd_addr,
    output sched_pkg::msg_kind_t             rd_kind,
    output logic                             done
);

    logic [2:0] state;

    // address = {frame, word}, like global_tp
    logic [sched_pkg::addr_w-sched_pkg::word_ptr_w-1:0] fp;
    logic [sched_pkg::word_ptr_w-1:0]                   wp;

    logic       in_hdr;     // walking the header frame words
    logic [5:0] if_left;    // instr frames still to send
    logic [1:0] fence_q;    // fence of the current task

    logic [sched_pkg::core_num-1:0] prev_mask;   // mask of the task before
    logic [sched_pkg::core_num-1:0] cur_mask;    // mask of this task
    logic [sched_pkg::core_num-1:0] gate_mask;
    logic                           mask_rd_q;   // core mask word returns this cycle

    sched_pkg::sched_word_u hdr_q;   // captured header word

    logic bp_ok;
    logic acq_hold;
    logic rel_ok;
    logic body_go;
    logic last_word;

    // header frame words check the older mask, instr words the task's own
    assign gate_mask = in_hdr ? prev_mask : cur_mask;
    assign bp_ok     = (core_reading & gate_mask) == gate_mask;   // zero mask passes

    // acquire holds the first word of the last instr frame
    assign acq_hold = (fence_q == sched_pkg::fence_acq) && !in_hdr
                      && (wp == '0) && (if_left == 6'd1)
                      && ((core_ready & prev_mask) != prev_mask);

    assign rel_ok    = (hdr_q.header.fence != sched_pkg::fence_rel) || (&core_ready);
    assign body_go   = (state == sched_pkg::st_body) && bp_ok && !acq_hold;
    assign last_word = wp == sched_pkg::word_ptr_w'(sched_pkg::frame_size - 1);

    assign rd_en   = !prog_loading && ((state == sched_pkg::st_hdr_rd) || body_go);
    assign rd_addr = {fp, wp};
    assign done    = state == sched_pkg::st_done;

    // kind travels with the read, header reads carry none
    always_comb begin
        rd_kind = sched_pkg::msg_none;
        if (rd_en && (state == sched_pkg::st_body)) begin
            if (!in_hdr) begin
                rd_kind = sched_pkg::msg_instr;
            end else if (wp == 4'd1) begin
                rd_kind = sched_pkg::msg_core_mask;
            end else if (wp == 4'd2) begin
                rd_kind = sched_pkg::msg_r0_mask;
            end else begin
                rd_kind = sched_pkg::msg_r0_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == sched_pkg::st_hdr_wait) begin
            hdr_q.raw <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= sched_pkg::st_idle;
            fp        <= '0;
            wp        <= '0;
            in_hdr    <= 1'b0;
            if_left   <= '0;
            fence_q   <= sched_pkg::fence_none;
            prev_mask <= '0;
            cur_mask  <= '0;
            mask_rd_q <= 1'b0;
        end else if (prog_loading) begin
            // restart at word 0 once loading ends
            state     <= sched_pkg::st_hdr_rd;
            fp        <= '0;
            wp        <= '0;
            in_hdr    <= 1'b0;
            if_left   <= '0;
            fence_q   <= sched_pkg::fence_none;
            prev_mask <= '0;
            cur_mask  <= '0;
            mask_rd_q <= 1'b0;
        end else begin
            mask_rd_q <= rd_en && (rd_kind == sched_pkg::msg_core_mask);
            if (mask_rd_q) begin
                cur_mask <= rd_data;   // same word the cores latch
            end
            case (state)
                sched_pkg::st_hdr_rd: begin
                    state <= sched_pkg::st_hdr_wait;
                end
                sched_pkg::st_hdr_wait: begin
                    state <= sched_pkg::st_hdr_dec;
                end
                sched_pkg::st_hdr_dec: begin
                    if (hdr_q.raw == '0) begin
                        state <= sched_pkg::st_done;   // end of program
                    end else if (rel_ok) begin
                        fence_q   <= hdr_q.header.fence;
                        if_left   <= hdr_q.header.if_num;
                        prev_mask <= cur_mask;
                        in_hdr    <= 1'b1;
                        wp        <= 4'd1;   // core mask word next
                        state     <= sched_pkg::st_body;
                    end
                end
                sched_pkg::st_body: begin
                    if (body_go) begin
                        if (in_hdr) begin
                            if (wp == 4'd2) begin
                                wp <= sched_pkg::word_ptr_w'(sched_pkg::r0_first);  // skip 3..7
                            end else if (last_word) begin
                                in_hdr <= 1'b0;
                                wp     <= '0;
                                fp     <= fp + 1'b1;
                                if (if_left == '0) begin
                                    state <= sched_pkg::st_hdr_rd;   // task without instrs
                                end
                            end else begin
                                wp <= wp + 1'b1;
                            end
                        end else begin
                            wp <= wp + 1'b1;   // wraps to 0 at frame end
                            if (last_word) begin
                                fp      <= fp + 1'b1;
                                if_left <= if_left - 1'b1;
                                if (if_left == 6'd1) begin
                                    state <= sched_pkg::st_hdr_rd;   // next header frame
                                end
                            end
                        end
                    end
                end
                sched_pkg::st_done: begin
                    state <= sched_pkg::st_done;   // until the next load
                end
                default: begin
                    state <= sched_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

// ==== scheduler/msg_issue.sv ====
module msg_issue (
    input  logic                         clk,
    input  logic                         reset,
    input  sched_pkg::msg_kind_t         rd_kind,
    input  logic [sched_pkg::word_w-1:0] rd_data,
    output logic [sched_pkg::word_w-1:0] mess_to_core,
    output logic                         core_mask_loading,
    output logic                         r0_mask_loading,
    output logic                         r0_loading,
    output logic                         instr_loading
);

    sched_pkg::msg_kind_t   kind_q;   // kind lined up with store data
    sched_pkg::sched_word_u bus_q;    // word on the message bus

    // store answers one cycle late, so the kind waits one cycle too
    always_ff @(posedge clk) begin
        if (reset) begin
            kind_q <= sched_pkg::msg_none;
        end else begin
            kind_q <= rd_kind;
        end
    end

    // bus only moves with a message, otherwise keeps the last word
    always_ff @(posedge clk) begin
        if (kind_q != sched_pkg::msg_none) begin
            bus_q.raw <= rd_data;
        end
    end

    // one strobe per message, one cycle wide
    always_ff @(posedge clk) begin
        if (reset) begin
            core_mask_loading <= 1'b0;
            r0_mask_loading   <= 1'b0;
            r0_loading        <= 1'b0;
            instr_loading     <= 1'b0;
        end else begin
            core_mask_loading <= kind_q == sched_pkg::msg_core_mask;
            r0_mask_loading   <= kind_q == sched_pkg::msg_r0_mask;
            r0_loading        <= kind_q == sched_pkg::msg_r0_data;
            instr_loading     <= kind_q == sched_pkg::msg_instr;
        end
    end

    assign mess_to_core = bus_q.raw;

endmodule

// ==== testbench/gpu_sva.sv ====
module gpu_sva (
    input logic                         clk,
    input logic                         reset,
    input logic                         prog_loading,
    input logic [sched_pkg::word_w-1:0] mess_to_core,
    input logic                         core_mask_loading,
    input logic                         r0_mask_loading,
    input logic                         r0_loading,
    input logic                         instr_loading,
    input logic                         done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] strobes;

    assign strobes = {core_mask_loading, r0_mask_loading, r0_loading, instr_loading};

    // one message kind per cycle
    one_strobe: assert property (@(posedge clk) disable iff (reset) $onehot0(strobes))
        else $error("two or more message strobes high together");

    quiet_load: assert property (@(posedge clk) disable iff (reset)
                                 prog_loading |-> strobes == '0)
        else $error("message strobe while the program is loading");

    quiet_done: assert property (@(posedge clk) disable iff (reset) done |-> strobes == '0)
        else $error("message strobe after done");

    // bus carries a known word whenever it is marked valid
    known_bus: assert property (@(posedge clk) disable iff (reset)
                                (|strobes) |-> !$isunknown(mess_to_core))
        else $error("mess_to_core unknown under a strobe");

endmodule

bind gpu_top gpu_sva u_sva (
    .clk               (clk),
    .reset             (reset),
    .prog_loading      (prog_loading),
    .mess_to_core      (mess_to_core),
    .core_mask_loading (core_mask_loading),
    .r0_mask_loading   (r0_mask_loading),
    .r0_loading        (r0_loading),
    .instr_loading     (instr_loading),
    .done              (done)
);

// ==== testbench/gpu_tb.sv ====
module gpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk = 1'b0;   // low before any process runs
    logic                           reset;
    logic                           prog_loading;
    logic                           prog_we;
    logic [sched_pkg::addr_w-1:0]   prog_addr;
    logic [sched_pkg::word_w-1:0]   prog_data;
    logic [sched_pkg::word_w-1:0]   mess_to_core;
    logic                           core_mask_loading;
    logic                           r0_mask_loading;
    logic                           r0_loading;
    logic                           instr_loading;
    logic [sched_pkg::core_num-1:0] core_ready;
    logic                           done;

    logic [sched_pkg::word_w-1:0] image [sched_pkg::data_depth];   // program image
    logic [31:0] lfsr = 32'h23a74091;

    int n_words;
    int cycle_cnt;
    int cycle_limit;
    int value_errors;
    int fence_errors;
    int other_errors;
    int instr_expected;
    int instr_seen;
    int bp_cycles;    // cycles with some core not reading
    int acq_checks;

    // expected traffic in bus order
    sched_pkg::msg_kind_t           exp_kind [$];
    logic [sched_pkg::word_w-1:0]   exp_word [$];
    logic                           exp_rel [$];    // core mask of a release task
    logic                           exp_acq [$];    // first word of an acquire task's last frame
    logic [sched_pkg::core_num-1:0] exp_gate [$];   // previous task's core mask
    logic [sched_pkg::core_num-1:0] ready_d1;
    logic [sched_pkg::core_num-1:0] ready_d2;       // core_ready two cycles back

    gpu_top u_dut (
        .clk               (clk),
        .reset             (reset),
        .prog_loading      (prog_loading),
        .prog_we           (prog_we),
        .prog_addr         (prog_addr),
        .prog_data         (prog_data),
        .mess_to_core      (mess_to_core),
        .core_mask_loading (core_mask_loading),
        .r0_mask_loading   (r0_mask_loading),
        .r0_loading        (r0_loading),
        .instr_loading     (instr_loading),
        .core_ready        (core_ready),
        .done              (done)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // six random tasks then a zero header, returns words used
    function automatic int build_program();
        int          base;
        int          ifn;
        logic [1:0]  fence;
        logic [15:0] hi;
        logic [15:0] mask;
        base = 0;
        for (int t = 0; t < 6; t++) begin
            ifn = 1 + rand_bits(2) % 3;   // one to three instr frames
            if (t < 2) begin
                fence = sched_pkg::fence_rel;
            end else if (t == 2) begin
                fence = sched_pkg::fence_acq;
            end else begin
                fence = 2'(rand_bits(2));
                if (fence == 2'd3) begin
                    fence = sched_pkg::fence_acq;
                end
            end
            hi   = rand_bits(8);   // reserved bits, ignored by the decode
            image[base] = {hi[7:0], fence, 6'(ifn)};
            mask = rand_bits(16);
            image[base + 1] = mask | (16'd1 << rand_bits(4));   // never an empty core mask
            for (int w = 2; w < 16 * (ifn + 1); w++) begin
                image[base + w] = rand_bits(16);   // r0 mask, spare, r0 data, instrs
            end
            base = base + 16 * (ifn + 1);
        end
        image[base] = '0;
        return base + 1;
    endfunction

    function automatic void push_expected(input sched_pkg::msg_kind_t kind,
                                          input logic [15:0] word, input logic rel,
                                          input logic acq, input logic [15:0] gate);
        exp_kind.push_back(kind);
        exp_word.push_back(word);
        exp_rel.push_back(rel);
        exp_acq.push_back(acq);
        exp_gate.push_back(gate);
        if (kind == sched_pkg::msg_instr) begin
            instr_expected++;
        end
    endfunction

    // frame walk: words 1, 2, 8..15 of the header, then whole instr frames
    function automatic int ref_messages();
        int          base;
        int          ifn;
        logic [1:0]  fence;
        logic [15:0] prev_mask;
        base      = 0;
        prev_mask = '0;
        while (image[base] != '0) begin
            fence = image[base][7:6];
            ifn   = image[base][5:0];
            push_expected(sched_pkg::msg_core_mask, image[base + 1],
                          fence == sched_pkg::fence_rel, 1'b0, prev_mask);
            push_expected(sched_pkg::msg_r0_mask, image[base + 2], 1'b0, 1'b0, prev_mask);
            for (int w = sched_pkg::r0_first; w < 16; w++) begin
                push_expected(sched_pkg::msg_r0_data, image[base + w], 1'b0, 1'b0, prev_mask);
            end
            for (int f = 1; f <= ifn; f++) begin
                for (int w = 0; w < 16; w++) begin
                    push_expected(sched_pkg::msg_instr, image[base + 16 * f + w], 1'b0,
                                  fence == sched_pkg::fence_acq && f == ifn && w == 0,
                                  prev_mask);
                end
            end
            prev_mask = image[base + 1];
            base      = base + 16 * (ifn + 1);
        end
        return exp_kind.size();
    endfunction

    task automatic load_program();
        prog_loading = 1'b1;
        for (int a = 0; a < n_words; a++) begin
            prog_we   = 1'b1;
            prog_addr = a[sched_pkg::addr_w-1:0];
            prog_data = image[a];
            @(posedge clk);
            #10;
        end
        prog_we      = 1'b0;
        prog_loading = 1'b0;
    endtask

    task automatic check_message(input sched_pkg::msg_kind_t kind);
        sched_pkg::msg_kind_t ek;
        logic [15:0]          ew;
        logic                 rel;
        logic                 acq;
        logic [15:0]          gate;
        ek   = exp_kind.pop_front();
        ew   = exp_word.pop_front();
        rel  = exp_rel.pop_front();
        acq  = exp_acq.pop_front();
        gate = exp_gate.pop_front();
        if (kind != ek) begin
            value_errors++;
            $display("ERROR %0t ns: strobe expected %s got %s", $time, ek.name(), kind.name());
        end
        if (mess_to_core !== ew) begin
            value_errors++;
            $display("ERROR %0t ns: mess_to_core expected %h got %h", $time, ew, mess_to_core);
        end
        if (kind == sched_pkg::msg_instr) begin
            instr_seen++;
        end
        if (rel && core_ready !== '1) begin
            fence_errors++;
            $display("%0t ns: release task core mask sent while core_ready was %h",
                     $time, core_ready);
        end
        if (acq) begin
            acq_checks++;
            if ((ready_d2 & gate) !== gate) begin   // read went out two cycles earlier
                fence_errors++;
                $display("%0t ns: acquire word read before cores %h were idle (core_ready %h)",
                         $time, gate, ready_d2);
            end
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin : compare_messages
        sched_pkg::msg_kind_t kind;
        int                   n_strobes;
        n_strobes = int'(core_mask_loading) + int'(r0_mask_loading)
                    + int'(r0_loading) + int'(instr_loading);
        kind = sched_pkg::msg_none;
        if (core_mask_loading) begin
            kind = sched_pkg::msg_core_mask;
        end else if (r0_mask_loading) begin
            kind = sched_pkg::msg_r0_mask;
        end else if (r0_loading) begin
            kind = sched_pkg::msg_r0_data;
        end else if (instr_loading) begin
            kind = sched_pkg::msg_instr;
        end
        if (u_dut.core_reading != '1) begin
            bp_cycles++;
        end
        if ((reset || prog_loading) && (n_strobes != 0 || done !== 1'b0)) begin
            other_errors++;
            $display("%0t ns: strobe or done high during reset or loading", $time);
        end else if (n_strobes > 1) begin
            other_errors++;
            $display("%0t ns: more than one strobe high in one cycle", $time);
        end else if (n_strobes == 1 && done === 1'b1) begin
            other_errors++;
            $display("%0t ns: message strobe after done", $time);
        end else if (n_strobes == 1 && exp_kind.size() == 0) begin
            other_errors++;
            $display("%0t ns: message beyond the end of the expected list", $time);
        end else if (n_strobes == 1) begin
            check_message(kind);
        end
        ready_d2 = ready_d1;
        ready_d1 = core_ready;
    end

    always @(posedge clk) begin : watchdog
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, done never rose", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin : stimulus
        reset        = 1'b1;
        prog_loading = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        n_words      = build_program();
        cycle_limit  = 16 + n_words + 64 * ref_messages() + 500;
        repeat (16) @(posedge clk);
        #10;
        reset = 1'b0;
        @(posedge clk);
        #10;
        load_program();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);   // catch stray strobes after done
        if (exp_kind.size() != 0) begin
            other_errors++;
            $display("%0d expected messages never arrived", exp_kind.size());
        end
        if (instr_seen != instr_expected) begin
            value_errors++;
            $display("ERROR %0t ns: instr_loading count expected %0d got %0d",
                     $time, instr_expected, instr_seen);
        end
        if (done !== 1'b1) begin
            value_errors++;
            $display("ERROR %0t ns: done expected 1 got %b", $time, done);
        end
        if (bp_cycles == 0) begin
            other_errors++;
            $display("core_reading never dropped, back-pressure was not exercised");
        end
        if (acq_checks == 0) begin
            other_errors++;
            $display("no acquire-fenced frame reached the checker");
        end
        $display("errors: %0d value, %0d fence, %0d other",
                 value_errors, fence_errors, other_errors);
        if (value_errors + fence_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
